//--- list.f
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/fetch_unit.sv
verilog/prefetch_buffer.sv
verilog/exec_unit.sv
verilog/core_top.sv
tb/tb_clock.sv
tb/core_asserts.sv
tb/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_core -f list.f -o tb_core_sim || exit 1
./obj_dir/tb_core_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

//--- tb/tb_core.sv
// Core testbench top
// Instruction memory model with LFSR grant and return delays, program
// image at the boot address, reference model of the ALU subset,
// retire checks, cycle limit and the final result message

module tb_core;

  timeunit 1ns;
  timeprecision 100ps;

  import core_pkg::*;
  import isa_pkg::*;

  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h100;
  localparam int PROG_LEN       = 40;
  localparam int PROG_AW        = $clog2(PROG_LEN);
  localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 50;

  logic            clk;
  logic            rst_n;
  logic            fetch_enable;
  logic [XLEN-1:0] boot_addr;
  logic            instr_req;
  logic            instr_gnt;
  logic            instr_rvalid;
  logic [XLEN-1:0] instr_addr;
  logic [XLEN-1:0] instr_rdata;
  retire_t         retire;

  logic [XLEN-1:0] prog [PROG_LEN];       // Program image
  logic [XLEN-1:0] ref_regs [NUM_REGS];   // Model register copy
  logic [31:0]     lfsr_q = 32'h9e13;
  int              retired_cnt = 0;
  int              cycle_cnt = 0;

  tb_clock clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  core_top DUT (
    .clk            ( clk          ),
    .rst_ni         ( rst_n        ),
    .fetch_enable_i ( fetch_enable ),
    .boot_addr_i    ( boot_addr    ),
    .instr_req_o    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rdata_i  ( instr_rdata  ),
    .retire_o       ( retire       )
  );

  bind core_top core_asserts asserts_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_i    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_i   ( instr_addr_o   ),
    .retire_i       ( retire_o       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Encoders, RV32I formats
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] op_rr(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [XLEN-1:0] op_addi(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [XLEN-1:0] op_lui(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), 7'b0110111};
  endfunction

  task automatic load_program();
    prog[0]  = op_lui(1, 32'h12345);        // Chained setups
    prog[1]  = op_addi(1, 1, 32'h678);
    prog[2]  = op_addi(2, 0, -5);
    prog[3]  = op_addi(3, 0, 7);
    prog[4]  = op_lui(4, 32'h80000);
    prog[5]  = op_addi(4, 4, -1);           // x4 = max positive
    prog[6]  = op_rr(0, 0, 5, 1, 2);        // ADD
    prog[7]  = op_rr(32, 0, 6, 3, 2);       // SUB
    prog[8]  = op_rr(0, 7, 7, 1, 4);        // AND
    prog[9]  = op_rr(0, 6, 8, 2, 3);        // OR
    prog[10] = op_rr(0, 4, 9, 1, 2);        // XOR
    prog[11] = op_rr(0, 2, 10, 2, 3);       // SLT neg < pos
    prog[12] = op_rr(0, 2, 11, 3, 2);
    prog[13] = op_addi(12, 0, -9);
    prog[14] = op_rr(0, 2, 13, 12, 2);      // SLT both negative
    prog[15] = op_rr(0, 2, 14, 2, 12);
    prog[16] = op_rr(0, 0, 0, 1, 3);        // Writes to x0
    prog[17] = op_addi(0, 0, 123);
    prog[18] = op_lui(0, 32'habcde);
    prog[19] = op_rr(0, 0, 15, 0, 3);       // Reads x0
    prog[20] = 32'hffff_ffff;               // Illegal opcode
    prog[21] = op_rr(32, 0, 16, 4, 2);      // SUB with wrap
    prog[22] = op_addi(17, 16, 2047);
    prog[23] = op_rr(0, 1, 18, 1, 3);       // SLL, outside subset
    prog[24] = op_rr(0, 6, 19, 18, 0);      // x18 must still be zero
    prog[25] = op_rr(0, 4, 20, 4, 4);
    prog[26] = op_rr(0, 7, 21, 2, 12);
    prog[27] = op_rr(0, 2, 22, 1, 1);
    prog[28] = op_rr(0, 2, 23, 4, 16);
    prog[29] = op_rr(0, 2, 24, 16, 4);
    prog[30] = op_addi(25, 24, -2048);
    prog[31] = op_lui(26, 32'hfffff);
    prog[32] = op_rr(0, 0, 27, 26, 25);
    prog[33] = op_rr(32, 0, 28, 0, 1);      // Negate through x0
    prog[34] = op_rr(0, 4, 29, 28, 5);
    prog[35] = op_rr(0, 6, 30, 29, 26);
    prog[36] = op_rr(0, 7, 31, 30, 1);
    prog[37] = op_addi(31, 31, 1);
    prog[38] = op_rr(0, 0, 1, 31, 17);
    prog[39] = op_rr(32, 0, 2, 1, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  // Delay of 0..2 cycles from two LFSR bits
  task automatic draw_delay(output int delay);
    logic [1:0] bits;
    for (int i = 0; i < 2; i++) begin
      lfsr_q  = lfsr_step(lfsr_q);
      bits[i] = lfsr_q[0];
    end
    delay = int'(bits) % 3;
  endtask

  function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    logic [11:0]     fill_imm;
    logic [XLEN-1:0] word;
    idx      = (addr - BOOT_ADDR) >> 2;
    fill_imm = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
    word     = {fill_imm, 20'h00013};        // ADDI x0 past the image
    if (addr >= BOOT_ADDR && idx < XLEN'(PROG_LEN)) word = prog[PROG_AW'(idx)];
    return word;
  endfunction

  initial begin : memory_model
    logic [XLEN-1:0] granted_q [$];          // Awaiting return, grant order
    logic [XLEN-1:0] req_addr;
    logic            req_seen;
    int              gnt_wait;
    int              ret_wait;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    req_seen     = 1'b0;
    req_addr     = '0;
    gnt_wait     = -1;
    ret_wait     = -1;
    forever begin
      @(posedge clk);
      #1;
      if (instr_gnt && req_seen) granted_q.push_back(req_addr);
      req_seen  = instr_req;
      req_addr  = instr_addr;
      instr_gnt = 1'b0;
      if (instr_req) begin
        if (gnt_wait < 0) draw_delay(gnt_wait);
        if (gnt_wait == 0) begin
          instr_gnt = 1'b1;
          gnt_wait  = -1;
        end else begin
          gnt_wait--;
        end
      end
      instr_rvalid = 1'b0;
      instr_rdata  = '0;
      if (granted_q.size() > 0) begin
        if (ret_wait < 0) draw_delay(ret_wait);
        if (ret_wait == 0) begin
          instr_rvalid = 1'b1;
          instr_rdata  = read_word(granted_q.pop_front());
          ret_wait     = -1;
        end else begin
          ret_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] ref_exec(input logic [XLEN-1:0] word,
                                               output logic ill);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    alu_op_e         op;
    a   = ref_regs[word[19:15]];
    b   = ref_regs[word[24:20]];
    ill = 1'b0;
    op  = ALU_ADD;
    case (word[6:0])
      7'b0110011: begin
        case ({word[31:25], word[14:12]})
          10'b0000000_000: op = ALU_ADD;
          10'b0100000_000: op = ALU_SUB;
          10'b0000000_010: op = ALU_SLT;
          10'b0000000_100: op = ALU_XOR;
          10'b0000000_110: op = ALU_OR;
          10'b0000000_111: op = ALU_AND;
          default:         ill = 1'b1;
        endcase
      end
      7'b0010011: begin
        b   = {{20{word[31]}}, word[31:20]};
        ill = (word[14:12] != 3'b000);     // Only ADDI
      end
      7'b0110111: begin
        b  = {word[31:12], 12'h000};
        op = ALU_PASS_B;
      end
      default: ill = 1'b1;
    endcase
    case (op)
      ALU_SUB:    res = a - b;
      ALU_AND:    res = a & b;
      ALU_OR:     res = a | b;
      ALU_XOR:    res = a ^ b;
      ALU_SLT:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_PASS_B: res = b;
      default:    res = a + b;
    endcase
    return res;
  endfunction

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic expect_eq(input string what, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s expected %h actual %h", what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_retire(input int idx, input retire_t r);
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] exp_res;
    logic            ill;
    logic            exp_we;
    string           name;
    word    = prog[PROG_AW'(idx)];
    exp_res = ref_exec(word, ill);
    exp_we  = !ill && (word[11:7] != 5'd0);  // x0 never written
    name    = $sformatf("instr %0d", idx);
    expect_eq({name, " addr"}, BOOT_ADDR + XLEN'(idx * INSTR_STEP), r.addr);
    expect_eq({name, " illegal"}, 32'(ill), 32'(r.illegal));
    expect_eq({name, " we"}, 32'(exp_we), 32'(r.we));
    expect_eq({name, " rd"}, 32'(word[11:7]), 32'(r.rd));
    if (!ill) expect_eq({name, " result"}, exp_res, r.result);
    if (exp_we) ref_regs[word[11:7]] = exp_res;
  endtask

  initial begin : stimulus
    fetch_enable = 1'b0;
    boot_addr    = BOOT_ADDR;
    load_program();
    @(posedge rst_n);
    repeat (3) @(posedge clk);               // Idle window after reset
    #1;
    fetch_enable = 1'b1;
  end

  initial begin : reference_model
    ref_regs = '{default: '0};
    @(posedge rst_n);
    while (retired_cnt < PROG_LEN) begin
      @(negedge clk);                        // Retire record stable here
      if (retire.valid) begin
        check_retire(retired_cnt, retire);
        retired_cnt++;
      end
    end
    if (!DUT.asserts_i.any_fail) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "Bound assertion failed");
    end
  end

  // Bound assertion failures and cycle limit
  always @(negedge clk) begin
    cycle_cnt++;
    if (DUT.asserts_i.any_fail) begin
      $display("A bound assertion on the core failed");
      fail_run();
    end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions retired",
               cycle_cnt, retired_cnt, PROG_LEN);
      fail_run();
    end
  end

endmodule

//--- tb/core_asserts.sv
// Concurrent checks bound into the core top level
// Idle before fetch enable, request address hold, in-flight limit,
// retire address order

module core_asserts (
  input logic                      clk,
  input logic                      rst_ni,
  input logic                      fetch_enable_i,
  input logic [core_pkg::XLEN-1:0] boot_addr_i,
  input logic                      instr_req_i,
  input logic                      instr_gnt_i,
  input logic                      instr_rvalid_i,
  input logic [core_pkg::XLEN-1:0] instr_addr_i,
  input core_pkg::retire_t         retire_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import core_pkg::*;

  logic            en_seen_q;          // Fetch enable sampled high once
  int              inflight_q;         // Granted, not yet returned
  logic [XLEN-1:0] next_addr_q;        // Address of the next retire
  logic            fail_idle  = 1'b0;
  logic            fail_hold  = 1'b0;
  logic            fail_limit = 1'b0;
  logic            fail_order = 1'b0;
  logic            any_fail;           // Watched by the testbench top

  assign any_fail = fail_idle | fail_hold | fail_limit | fail_order;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      en_seen_q   <= 1'b0;
      inflight_q  <= 0;
      next_addr_q <= boot_addr_i;
    end else begin
      en_seen_q  <= en_seen_q | fetch_enable_i;
      inflight_q <= inflight_q + int'(instr_req_i && instr_gnt_i) - int'(instr_rvalid_i);
      if (retire_i.valid) next_addr_q <= next_addr_q + XLEN'(INSTR_STEP);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory handshake
  ////////////////////////////////////////////////////////////////////////////

  idle_before_enable: assert property (@(posedge clk) disable iff (!rst_ni)
    !en_seen_q |-> !instr_req_i && !retire_i.valid)
    else begin
      fail_idle = 1'b1;
      $error("request or retire seen before fetch enable");
    end

  // Ungranted request keeps its address
  addr_held: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else begin
      fail_hold = 1'b1;
      $error("request dropped or address changed before grant");
    end

  inflight_limit: assert property (@(posedge clk) disable iff (!rst_ni)
    (inflight_q <= FETCH_DEPTH) && (!instr_rvalid_i || inflight_q > 0))
    else begin
      fail_limit = 1'b1;
      $error("in-flight request count out of range");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Retire port
  ////////////////////////////////////////////////////////////////////////////

  retire_in_order: assert property (@(posedge clk) disable iff (!rst_ni)
    retire_i.valid |-> retire_i.addr == next_addr_q)
    else begin
      fail_order = 1'b1;
      $error("retired address out of sequence");
    end

endmodule

//--- tb/tb_clock.sv
// Testbench clock and reset generator
// 8 ns clock, active-low reset held for two cycles

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;        // 8 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;                 // Released just after the edge
  end

endmodule

//--- verilog/core_top.sv
// Core top level
// Fetch unit, prefetch buffer and execute unit between the instruction
// memory port and the retire port

module core_top (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  // Instruction memory interface
  output logic                      instr_req_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  // Retire port
  output core_pkg::retire_t         retire_o
);

  import core_pkg::*;

  logic [CNT_W-1:0] buf_count;
  logic             push;
  fetch_entry_t     push_entry;    // Fetch to buffer
  logic             buf_valid;
  fetch_entry_t     buf_entry;     // Buffer to execute
  logic             exec_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  fetch_unit fetch_unit_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .buf_count_i    ( buf_count      ),
    .push_o         ( push           ),
    .entry_o        ( push_entry     )
  );

  prefetch_buffer prefetch_buffer_i (
    .clk     ( clk        ),
    .rst_ni  ( rst_ni     ),
    .push_i  ( push       ),
    .entry_i ( push_entry ),
    .count_o ( buf_count  ),
    .valid_o ( buf_valid  ),
    .entry_o ( buf_entry  ),
    .ready_i ( exec_ready )
  );

  exec_unit exec_unit_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .valid_i        ( buf_valid      ),
    .entry_i        ( buf_entry      ),
    .ready_o        ( exec_ready     ),
    .fetch_enable_i ( fetch_enable_i ),
    .retire_o       ( retire_o       )
  );

endmodule

//--- verilog/exec_unit.sv
// Execute unit
// Decoder for the ADD/SUB/AND/OR/XOR/SLT/ADDI/LUI subset, ALU,
// 32-entry register file and registered retire record

module exec_unit (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  input  core_pkg::fetch_entry_t entry_i,
  output logic                   ready_o,
  input  logic                   fetch_enable_i,
  output core_pkg::retire_t      retire_o
);

  import core_pkg::*;
  import isa_pkg::*;

  logic [XLEN-1:0]       rf_q [NUM_REGS];  // Integer register file
  logic [XLEN-1:0]       instr;
  logic [OPCODE_W-1:0]   opcode;
  logic [FUNCT3_W-1:0]   funct3;
  logic [FUNCT7_W-1:0]   funct7;
  logic [REG_ADDR_W-1:0] rd, rs1, rs2;
  logic [XLEN-1:0]       imm_i, imm_u, imm;
  logic [XLEN-1:0]       op_a, op_b, result;
  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  illegal;
  logic                  fire;
  logic                  rf_we;
  retire_t               retire_q;

  assign ready_o = fetch_enable_i;         // Single-cycle execute, no stall
  assign fire    = valid_i && ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign instr  = entry_i.instr;
  assign opcode = instr[OPCODE_W-1:0];
  assign rd     = instr[RD_LSB +: REG_ADDR_W];
  assign rs1    = instr[RS1_LSB +: REG_ADDR_W];
  assign rs2    = instr[RS2_LSB +: REG_ADDR_W];
  assign funct3 = instr[FUNCT3_LSB +: FUNCT3_W];
  assign funct7 = instr[FUNCT7_LSB +: FUNCT7_W];
  assign imm_i  = {{(XLEN - IMM_I_W){instr[XLEN-1]}}, instr[XLEN-1 -: IMM_I_W]};
  assign imm_u  = {instr[XLEN-1 -: IMM_U_W], {(XLEN - IMM_U_W){1'b0}}};

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    imm     = imm_i;
    illegal = 1'b0;
    case (opcode)
      OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD_SUB: alu_op = ALU_ADD;
            F3_SLT:     alu_op = ALU_SLT;
            F3_XOR:     alu_op = ALU_XOR;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    illegal = 1'b1;   // Shifts, SLTU
          endcase
        end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
          alu_op = ALU_SUB;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_IMM: begin
        use_imm = 1'b1;                    // ADDI only
        illegal = (funct3 != F3_ADD_SUB);
      end
      LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u;
      end
      default: illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  assign op_a = rf_q[rs1];                 // x0 is never written, reads zero
  assign op_b = use_imm ? imm : rf_q[rs2];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_OR:     result = op_a | op_b;
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SLT:    result = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file and retire record
  ////////////////////////////////////////////////////////////////////////////

  assign rf_we = fire && !illegal && (rd != '0);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_we) begin
      rf_q[rd] <= result;
    end
  end

  // Retire one cycle after the transfer
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_q <= '0;
    end else begin
      retire_q.valid <= fire;
      if (fire) begin
        retire_q.addr    <= entry_i.addr;
        retire_q.rd      <= rd;
        retire_q.we      <= rf_we;         // Low for x0 and illegal words
        retire_q.result  <= result;
        retire_q.illegal <= illegal;
      end
    end
  end

  assign retire_o = retire_q;

endmodule

//--- verilog/prefetch_buffer.sv
// Prefetch buffer
// Circular FIFO of fetched words with their addresses, push and pop
// allowed in the same cycle, occupancy reported back to fetch

module prefetch_buffer (
  input  logic                       clk,
  input  logic                       rst_ni,
  // From fetch
  input  logic                       push_i,
  input  core_pkg::fetch_entry_t     entry_i,
  output logic [core_pkg::CNT_W-1:0] count_o,
  // To execute
  output logic                       valid_o,
  output core_pkg::fetch_entry_t     entry_o,
  input  logic                       ready_i
);

  import core_pkg::*;

  fetch_entry_t     mem_q [FETCH_DEPTH];   // Entry storage
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  assign valid_o = (count_q != '0);
  assign entry_o = mem_q[rd_ptr_q];        // Oldest entry
  assign count_o = count_q;
  assign pop     = valid_o && ready_i;

  // No overflow check, fetch never requests past free space
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;                         // Simultaneous push/pop keeps count
      endcase
    end
  end

endmodule

//--- verilog/fetch_unit.sv
// Instruction fetch unit
// Sequential PC starting at the boot address, request/grant/rvalid
// memory handshake, queue of granted addresses, in-flight counter

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0]  boot_addr_i,
  // Instruction memory
  output logic                       instr_req_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  output logic [core_pkg::XLEN-1:0]  instr_addr_o,
  input  logic [core_pkg::XLEN-1:0]  instr_rdata_i,
  // Prefetch buffer
  input  logic [core_pkg::CNT_W-1:0] buf_count_i,
  output logic                       push_o,
  output core_pkg::fetch_entry_t     entry_o
);

  import core_pkg::*;

  logic             fetch_en_q;                  // Enable seen last cycle
  logic             booted_q;                    // PC taken from boot address
  logic [XLEN-1:0]  pc_q;                        // Next address to request
  logic [XLEN-1:0]  addr_q [FETCH_DEPTH];        // Granted, awaiting rvalid
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] out_cnt_q;                   // Requests in flight
  logic [CNT_W:0]   budget;
  logic             granted;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // In flight plus buffered words may never exceed the buffer size
  assign budget       = {1'b0, out_cnt_q} + {1'b0, buf_count_i};
  assign instr_req_o  = fetch_en_q && (budget < (CNT_W + 1)'(FETCH_DEPTH));
  assign instr_addr_o = pc_q;                    // Held until granted
  assign granted      = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
      booted_q   <= 1'b0;
      pc_q       <= '0;
    end else begin
      fetch_en_q <= fetch_enable_i;
      booted_q   <= booted_q | fetch_en_q;
      if (!booted_q) pc_q <= boot_addr_i;        // Track boot address until start
      if (granted) pc_q <= pc_q + XLEN'(INSTR_STEP);  // Wins over boot load
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Granted address queue, popped in grant order by rvalid
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (granted) begin
      addr_q[wr_ptr_q] <= pc_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      out_cnt_q <= '0;
    end else begin
      if (granted) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({granted, instr_rvalid_i})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;  // New request only
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;  // Return only
        default: ;                               // Both or neither
      endcase
    end
  end

  // Returned word goes straight into the buffer with its address
  assign push_o        = instr_rvalid_i;
  assign entry_o.addr  = addr_q[rd_ptr_q];
  assign entry_o.instr = instr_rdata_i;

endmodule

//--- verilog/isa_pkg.sv
// RV32I encoding subset used by the execute unit
// Major opcodes, ALU operation codes, instruction field positions,
// funct3 and funct7 codes of the supported operations

package isa_pkg;

  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  // Major opcodes kept in the subset
  typedef enum logic [OPCODE_W-1:0] {
    OP     = 7'b0110011,    // Register-register
    OP_IMM = 7'b0010011,    // Register-immediate
    LUI    = 7'b0110111     // Upper immediate
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6     // Operand b straight through, LUI
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Field positions (lsb of each field)
  ////////////////////////////////////////////////////////////////////////////

  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  localparam int IMM_I_W = 12;    // I-type immediate, top of word
  localparam int IMM_U_W = 20;    // U-type immediate, top of word

  // funct3 / funct7 codes
  localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_SUB  = 7'b0100000;

endpackage

//--- verilog/core_pkg.sv
// Machine-level sizes of the core
// Fetch entry record passed from fetch to prefetch buffer to execute
// Retire record reported at the core boundary

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN        = 32;                  // Data and address width
  localparam int NUM_REGS    = 32;                  // Integer register count
  localparam int REG_ADDR_W  = 5;                   // Register index width
  localparam int FETCH_DEPTH = 2;                   // Buffer slots, max in flight
  localparam int INSTR_STEP  = 4;                   // Byte step per instruction

  // Occupancy counter must hold 0..FETCH_DEPTH
  localparam int CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int PTR_W = $clog2(FETCH_DEPTH);       // Circular pointer width

  ////////////////////////////////////////////////////////////////////////////
  // Records between stages
  ////////////////////////////////////////////////////////////////////////////

  // One fetched instruction with the address it came from
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] instr;
  } fetch_entry_t;

  // One retired instruction
  typedef struct packed {
    logic                  valid;    // High for one cycle per retire
    logic [XLEN-1:0]       addr;     // Address of the retired word
    logic [REG_ADDR_W-1:0] rd;       // Destination index
    logic                  we;       // Register actually written
    logic [XLEN-1:0]       result;   // ALU result
    logic                  illegal;  // Word outside the supported subset
  } retire_t;

endpackage
